// File: verilog.f
hw/icache_pkg.sv
hw/icache_bram.sv
hw/icache.sv
hw/fetch_unit.sv
hw/fetch_top.sv
dv/tb_memory_model.sv
dv/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_top

sources:
  - files:
      - hw/icache_pkg.sv
      - hw/icache_bram.sv
      - hw/icache.sv
      - hw/fetch_unit.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - dv/tb_memory_model.sv
      - dv/tb_fetch_top.sv

// File: dv/tb_fetch_top.sv
/*
 Testbench for the fetch front end.
 Random back-pressure, redirects and flushes, then a counted two pass loop.
*/

module tb_fetch_top import icache_pkg::*;;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int    INDEX_BITS = 4;
	localparam word_t RESET_PC   = DEFAULT_RESET_PC;
	localparam word_t PATTERN    = 32'hA5A5_0000;
	localparam int    RANDOM_CYCLES = 1500;
	localparam int    CYCLE_LIMIT   = 4000;

	logic  i_clock;
	logic  i_reset;
	logic  i_flush;
	logic  i_redirect;
	word_t i_redirect_pc;
	logic  i_instr_ready;
	logic  o_bus_request;
	word_t o_bus_address;
	logic  bus_ready;
	word_t bus_rdata;
	logic  o_instr_valid;
	word_t o_instr;
	word_t o_instr_pc;
	word_t o_hit_count;
	word_t o_miss_count;
	word_t request_count;

	logic [31:0] lfsr;
	int          cycles;
	int          data_errors;
	int          order_errors;
	int          hold_errors;
	int          bus_errors;
	int          count_errors;
	int          accepted;
	int          clear_left;
	logic        flush_wait;
	word_t       expected_pc;

	fetch_top #(
		.INDEX_BITS(INDEX_BITS),
		.RESET_PC  (RESET_PC)
	) i_fetch_top (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_flush      (i_flush),
		.i_redirect   (i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready  (bus_ready),
		.i_bus_rdata  (bus_rdata),
		.o_instr_valid(o_instr_valid),
		.o_instr      (o_instr),
		.o_instr_pc   (o_instr_pc),
		.i_instr_ready(i_instr_ready),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

	tb_memory_model i_tb_memory_model (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_bus_request  (o_bus_request),
		.i_bus_address  (o_bus_address),
		.o_bus_ready    (bus_ready),
		.o_bus_rdata    (bus_rdata),
		.o_request_count(request_count)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	task automatic draw_bits(input int count, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic wait_accept(input word_t pc);
		do begin
			@(posedge i_clock);
		end while (!(o_instr_valid && i_instr_ready && o_instr_pc == pc));
	endtask

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	// Accepted words carry the memory pattern.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_instr_valid && i_instr_ready |-> o_instr == (o_instr_pc ^ PATTERN))
	else begin
		data_errors++;
		$display("[ERROR] o_instr %h expected %h", o_instr, o_instr_pc ^ PATTERN);
	end

	// Stalled output holds.
	assert property (@(posedge i_clock) disable iff (i_reset)
		o_instr_valid && !i_instr_ready && !i_redirect |=>
		o_instr_valid && $stable(o_instr) && $stable(o_instr_pc))
	else begin
		hold_errors++;
		$display("[ERROR] o_instr_pc %h changed under back-pressure", o_instr_pc);
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !bus_ready |=> o_bus_request && $stable(o_bus_address))
	else begin
		bus_errors++;
		$display("[ERROR] o_bus_address %h dropped or moved before ready", o_bus_address);
	end

	// Program order and the clear window after reset or flush.
	always @(posedge i_clock) begin
		if (i_reset) begin
			expected_pc <= RESET_PC;
			clear_left  <= 1 << INDEX_BITS;
			flush_wait  <= 1'b0;
			accepted    <= 0;
		end else begin
			if (o_instr_valid && i_instr_ready) begin
				assert (o_instr_pc == expected_pc)
				else begin
					order_errors++;
					$display("[ERROR] o_instr_pc %h expected %h", o_instr_pc, expected_pc);
				end
				accepted    <= accepted + 1;
				expected_pc <= expected_pc + 32'd4;
			end
			if (i_redirect) begin
				expected_pc <= i_redirect_pc;
			end
			if (clear_left != 0) begin
				assert (!o_bus_request)
				else begin
					bus_errors++;
					$display("[ERROR] o_bus_request %h during clear", o_bus_request);
				end
				clear_left <= clear_left - 1;
			end
			if (i_flush && o_bus_request && !bus_ready) begin
				flush_wait <= 1'b1;
			end else if (i_flush || (flush_wait && bus_ready)) begin
				flush_wait <= 1'b0;
				clear_left <= 1 << INDEX_BITS;
			end
		end
	end

	always @(posedge i_clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [7:0] bits;
		word_t      hits_start;
		word_t      misses_start;
		int         accepted_start;
		lfsr = 32'hbff1;
		cycles = 0;
		data_errors = 0;
		order_errors = 0;
		hold_errors = 0;
		bus_errors = 0;
		count_errors = 0;
		i_reset = 1'b1;
		i_flush = 1'b0;
		i_redirect = 1'b0;
		i_redirect_pc = '0;
		i_instr_ready = 1'b0;
		repeat (5) @(posedge i_clock);
		i_reset <= 1'b0;

		// Random back-pressure, loops in the boot window, rare flushes.
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			@(posedge i_clock);
			draw_bits(1, bits);
			i_instr_ready <= bits[0];
			draw_bits(5, bits);
			i_redirect <= (bits[4:0] == 5'd0);
			draw_bits(4, bits);
			i_redirect_pc <= RESET_PC + {bits[3:0], 2'b00};
			draw_bits(6, bits);
			i_flush <= (bits[5:0] == 6'd0);
		end

		// Cache the whole boot window before the flush.
		@(posedge i_clock);
		i_instr_ready <= 1'b1;
		i_flush       <= 1'b0;
		i_redirect    <= 1'b1;
		i_redirect_pc <= RESET_PC;
		@(posedge i_clock);
		i_redirect <= 1'b0;
		wait_accept(RESET_PC + 32'd60);

		// Flush, then loop twice over the boot window.
		i_flush    <= 1'b1;
		i_redirect <= 1'b1;
		@(posedge i_clock);
		i_flush    <= 1'b0;
		i_redirect <= 1'b0;
		@(posedge i_clock);
		hits_start     = o_hit_count;
		misses_start   = o_miss_count;
		accepted_start = accepted;
		wait_accept(RESET_PC + 32'd60);
		i_redirect <= 1'b1;
		@(posedge i_clock);
		i_redirect <= 1'b0;
		wait_accept(RESET_PC + 32'd60);
		// The last word is counted one edge later.
		assert (o_miss_count - misses_start == 32'd16)
		else begin
			count_errors++;
			$display("[ERROR] o_miss_count delta %h expected %h",
				o_miss_count - misses_start, 32'd16);
		end
		assert (o_hit_count - hits_start == word_t'(accepted - accepted_start + 1 - 16))
		else begin
			count_errors++;
			$display("[ERROR] o_hit_count delta %h expected %h",
				o_hit_count - hits_start, accepted - accepted_start + 1 - 16);
		end

		// Hold the redirect until the bus is idle.
		i_redirect <= 1'b1;
		@(posedge i_clock);
		while (o_bus_request) begin
			@(posedge i_clock);
		end
		assert (o_miss_count == request_count)
		else begin
			count_errors++;
			$display("[ERROR] o_miss_count %h expected %h", o_miss_count, request_count);
		end
		i_redirect <= 1'b0;
		@(posedge i_clock);

		$display("Errors: data %0d, order %0d, hold %0d, bus %0d, count %0d",
			data_errors, order_errors, hold_errors, bus_errors, count_errors);
		if (data_errors + order_errors + hold_errors + bus_errors + count_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: dv/tb_memory_model.sv
/*
 Memory bus responder for the fetch testbench.
 Answers each request after 0 to 3 extra cycles with address XOR A5A5_0000.
*/

module tb_memory_model import icache_pkg::*; (
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_bus_request,
	input  word_t i_bus_address,
	output logic  o_bus_ready,
	output word_t o_bus_rdata,
	output word_t o_request_count
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] lfsr;
	logic        pending;
	logic [1:0]  delay;

	// Galois LFSR, taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// One LFSR step per bit taken.
	task automatic draw_delay(output logic [1:0] value);
		for (int i = 0; i < 2; i++) begin
			value[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	initial begin
		lfsr = 32'hbff1;
	end

	always @(posedge i_clock) begin
		logic [1:0] wait_cycles;
		if (i_reset) begin
			o_bus_ready     <= 1'b0;
			o_bus_rdata     <= '0;
			pending         <= 1'b0;
			delay           <= '0;
			o_request_count <= '0;
		end else begin
			o_bus_ready <= 1'b0;
			if (o_bus_ready) begin
				// Transfer ends this cycle, the request drops next.
			end else if (i_bus_request && !pending) begin
				draw_delay(wait_cycles);
				pending         <= 1'b1;
				delay           <= wait_cycles;
				o_request_count <= o_request_count + 32'd1;
			end else if (pending) begin
				if (delay == 2'd0) begin
					o_bus_ready <= 1'b1;
					o_bus_rdata <= i_bus_address ^ 32'hA5A5_0000;
					pending     <= 1'b0;
				end else begin
					delay <= delay - 2'd1;
				end
			end
		end
	end

endmodule

// File: hw/fetch_top.sv
/*
 Instruction fetch front end.
 Fetch unit in front of the instruction cache and its memory bus.
*/

module fetch_top import icache_pkg::*; #(
	parameter int    INDEX_BITS = DEFAULT_INDEX_BITS,
	parameter word_t RESET_PC   = DEFAULT_RESET_PC
) (
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_flush,
	input  logic  i_redirect,
	input  word_t i_redirect_pc,

	// Memory bus.
	output logic  o_bus_request,
	output word_t o_bus_address,
	input  logic  i_bus_ready,
	input  word_t i_bus_rdata,

	// Instruction stream.
	output logic  o_instr_valid,
	output word_t o_instr,
	output word_t o_instr_pc,
	input  logic  i_instr_ready,

	output word_t o_hit_count,
	output word_t o_miss_count
);

	logic  req_valid;
	word_t req_pc;
	logic  resp_valid;
	word_t resp_instr;
	logic  resp_ready;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) i_fetch_unit (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_redirect   (i_redirect),
		.i_redirect_pc(i_redirect_pc),
		.o_req_valid  (req_valid),
		.o_req_pc     (req_pc),
		.i_resp_valid (resp_valid),
		.i_resp_instr (resp_instr),
		.o_resp_ready (resp_ready),
		.o_instr_valid(o_instr_valid),
		.o_instr      (o_instr),
		.o_instr_pc   (o_instr_pc),
		.i_instr_ready(i_instr_ready)
	);

	icache #(
		.INDEX_BITS(INDEX_BITS)
	) i_icache (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_flush      (i_flush),
		.i_req_valid  (req_valid),
		.i_req_pc     (req_pc),
		.o_resp_valid (resp_valid),
		.o_resp_instr (resp_instr),
		.i_resp_ready (resp_ready),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready  (i_bus_ready),
		.i_bus_rdata  (i_bus_rdata),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

endmodule

// File: hw/fetch_unit.sv
/*
 Fetch unit.
 Program counter, redirects and a one entry output stage toward decode.
*/

module fetch_unit import icache_pkg::*; #(
	parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
	input  logic  i_clock,
	input  logic  i_reset,

	input  logic  i_redirect,
	input  word_t i_redirect_pc,

	output logic  o_req_valid,
	output word_t o_req_pc,

	input  logic  i_resp_valid,
	input  word_t i_resp_instr,
	output logic  o_resp_ready,

	output logic  o_instr_valid,
	output word_t o_instr,
	output word_t o_instr_pc,
	input  logic  i_instr_ready
);

	word_t pc;
	logic  out_valid;
	word_t out_instr;
	word_t out_pc;
	logic  resp_ready;
	logic  accept;

	// No request while the pc is being replaced.
	assign o_req_valid = !i_redirect;
	assign o_req_pc    = pc;

	// Room when empty or drained this cycle.
	assign resp_ready   = !out_valid || i_instr_ready;
	assign o_resp_ready = resp_ready;

	assign accept = i_resp_valid && resp_ready && !i_redirect;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pc        <= RESET_PC;
			out_valid <= 1'b0;
		end else if (i_redirect) begin
			pc        <= i_redirect_pc;
			out_valid <= 1'b0;
		end else if (accept) begin
			pc        <= pc + 32'd4;
			out_valid <= 1'b1;
		end else if (i_instr_ready) begin
			out_valid <= 1'b0;
		end
	end

	// Payload holds under back-pressure.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			out_instr <= i_resp_instr;
			out_pc    <= pc;
		end
	end

	assign o_instr_valid = out_valid;
	assign o_instr       = out_instr;
	assign o_instr_pc    = out_pc;

endmodule

// File: hw/icache.sv
/*
 Direct mapped instruction cache, one word per line.
 Clears on reset and flush, refills over the request/ready bus, counts hits and misses.
*/

module icache import icache_pkg::*; #(
	parameter int INDEX_BITS = DEFAULT_INDEX_BITS
) (
	input  logic  i_clock,
	input  logic  i_reset,
	input  logic  i_flush,

	input  logic  i_req_valid,
	input  word_t i_req_pc,

	output logic  o_resp_valid,
	output word_t o_resp_instr,
	input  logic  i_resp_ready,

	output logic  o_bus_request,
	output word_t o_bus_address,
	input  logic  i_bus_ready,
	input  word_t i_bus_rdata,

	output word_t o_hit_count,
	output word_t o_miss_count
);

	localparam int LINES = 1 << INDEX_BITS;

	icache_state_e state;
	icache_state_e next_state;

	logic [INDEX_BITS-1:0] sweep;
	logic                  flush_pending;
	logic                  flush_now;

	// Line layout is { instruction, word address, 1'b0, valid }.
	logic                  ram_write;
	logic [INDEX_BITS-1:0] ram_address;
	logic [63:0]           ram_wdata;
	logic [63:0]           ram_rdata;

	// Index the RAM output belongs to.
	logic [INDEX_BITS-1:0] lookup_index;

	word_t                 miss_address;
	word_t                 req_pc_next;
	logic [INDEX_BITS-1:0] req_index;
	logic [INDEX_BITS-1:0] next_index;
	logic [INDEX_BITS-1:0] miss_index;
	logic                  index_match;
	logic                  tag_match;
	logic                  req_is_miss;

	logic                  hit_event;
	logic                  miss_event;
	word_t                 hit_count;
	word_t                 miss_count;

	icache_bram #(
		.DEPTH(LINES),
		.WIDTH(64)
	) i_icache_bram (
		.i_clock  (i_clock),
		.i_write  (ram_write),
		.i_address(ram_address),
		.i_wdata  (ram_wdata),
		.o_rdata  (ram_rdata)
	);

	assign req_pc_next = i_req_pc + 32'd4;
	assign req_index   = i_req_pc[INDEX_BITS+1:2];
	assign next_index  = req_pc_next[INDEX_BITS+1:2];
	assign miss_index  = miss_address[INDEX_BITS+1:2];

	assign index_match = (lookup_index == req_index);
	assign tag_match   = (ram_rdata[31:0] == {i_req_pc[31:2], 2'b01});
	assign req_is_miss = (i_req_pc == miss_address);

	// A flush seen in the ready cycle itself also blocks the line write.
	assign flush_now = flush_pending | i_flush;

	assign o_bus_address = miss_address;
	assign o_hit_count   = hit_count;
	assign o_miss_count  = miss_count;

	always_comb begin
		next_state    = state;
		ram_write     = 1'b0;
		ram_address   = req_index;
		ram_wdata     = {i_bus_rdata, miss_address[31:2], 2'b01};
		o_resp_valid  = 1'b0;
		o_resp_instr  = ram_rdata[63:32];
		o_bus_request = 1'b0;
		hit_event     = 1'b0;
		miss_event    = 1'b0;

		case (state)
			ICACHE_CLEAR: begin
				ram_write   = 1'b1;
				ram_address = sweep;
				ram_wdata   = '0;
				if (!i_flush && (&sweep)) begin
					next_state = ICACHE_LOOKUP;
				end
			end

			ICACHE_LOOKUP: begin
				if (i_flush) begin
					next_state = ICACHE_CLEAR;
				end else if (i_req_valid) begin
					if (!index_match) begin
						next_state = ICACHE_REPLAY;
					end else if (tag_match) begin
						o_resp_valid = 1'b1;
						// Start reading the following word early.
						if (i_resp_ready) begin
							ram_address = next_index;
							hit_event   = 1'b1;
						end
					end else begin
						miss_event = 1'b1;
						next_state = ICACHE_REFILL;
					end
				end
			end

			ICACHE_REPLAY: begin
				next_state = i_flush ? ICACHE_CLEAR : ICACHE_LOOKUP;
			end

			ICACHE_REFILL: begin
				o_bus_request = 1'b1;
				if (i_bus_ready) begin
					o_resp_valid = i_req_valid && req_is_miss;
					o_resp_instr = i_bus_rdata;
					if (!flush_now) begin
						ram_write   = 1'b1;
						ram_address = miss_index;
					end
					if (flush_now) begin
						next_state = ICACHE_CLEAR;
					end else if (i_req_valid && req_is_miss && !i_resp_ready) begin
						// Same pc next cycle, the written line is read back.
						next_state = ICACHE_LOOKUP;
					end else begin
						next_state = ICACHE_REPLAY;
					end
				end
			end

			default: begin
				next_state = ICACHE_CLEAR;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state         <= ICACHE_CLEAR;
			sweep         <= '0;
			flush_pending <= 1'b0;
			hit_count     <= '0;
			miss_count    <= '0;
		end else begin
			state <= next_state;
			// Restart the sweep when a flush lands mid clear.
			sweep <= (state == ICACHE_CLEAR && !i_flush) ? sweep + 1'b1 : '0;
			flush_pending <= (state == ICACHE_REFILL) && !i_bus_ready && flush_now;
			if (hit_event) begin
				hit_count <= hit_count + 32'd1;
			end
			if (miss_event) begin
				miss_count <= miss_count + 32'd1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		lookup_index <= ram_address;
		if (miss_event) begin
			miss_address <= i_req_pc;
		end
	end

endmodule

// File: hw/icache_bram.sv
/*
 Cache line storage.
 Single port block RAM, registered read, write-first.
*/

module icache_bram #(
	parameter int DEPTH = 64,
	parameter int WIDTH = 64
) (
	input  logic                     i_clock,
	input  logic                     i_write,
	input  logic [$clog2(DEPTH)-1:0] i_address,
	input  logic [WIDTH-1:0]         i_wdata,
	output logic [WIDTH-1:0]         o_rdata
);

	logic [WIDTH-1:0] memory [DEPTH];

	// Written data shows up on the read port right away.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			memory[i_address] <= i_wdata;
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= memory[i_address];
		end
	end

endmodule

// File: hw/icache_pkg.sv
/*
 Instruction fetch package.
 Shared word type, cache controller states and top level defaults.
*/

package icache_pkg;

	// One instruction or one byte address.
	typedef logic [31:0] word_t;

	// Cache controller states.
	typedef enum logic [1:0] {
		// Sweeping zero into every line.
		ICACHE_CLEAR  = 2'd0,
		// Tag from the RAM compared with the requested pc.
		ICACHE_LOOKUP = 2'd1,
		// Bus request outstanding.
		ICACHE_REFILL = 2'd2,
		// Idle cycle while the RAM is read at a new index.
		ICACHE_REPLAY = 2'd3
	} icache_state_e;

	// 64 lines by default.
	localparam int DEFAULT_INDEX_BITS = 6;

	// Boot address.
	localparam word_t DEFAULT_RESET_PC = 32'h0000_0100;

endpackage
